//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the etx_core testbench with Verilator
set -e
cd "$(dirname "$0")"
mkdir -p build
verilator --binary --timing -f sources.f --top-module etx_core_tb \
   -Mdir build/obj_dir -o etx_core_sim
./build/obj_dir/etx_core_sim > build/sim.log 2>&1 || true
cat build/sim.log
if grep -q '\*\*\* FAILED \*\*\*' build/sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' build/sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi

//--- sources.f
+incdir+verilog
verilog/etx_pkg.sv
verilog/etx_arbiter.sv
verilog/etx_remap.sv
verilog/etx_cfg.sv
verilog/etx_protocol.sv
verilog/etx_core.sv
tests/etx_core_tb.sv

//--- tests/etx_core_tb.sv
`timescale 1ns/100ps
`include "etx_config.svh"

module etx_core_tb;
   import etx_pkg::*;

   localparam int NCOL     = 9;    // Words per trace line
   localparam int MAXW     = 1024;
   localparam int GAP      = 12;   // Quiet cycles after each group
   localparam int LINE_CYC = 200;  // Watchdog budget per trace line

   logic               clk;
   logic               rst;
   logic               txwr_access;
   logic               txrd_access;
   logic               txrr_access;
   emesh_packet_t      txwr_packet;
   emesh_packet_t      txrd_packet;
   emesh_packet_t      txrr_packet;
   logic               txwr_wait;
   logic               txrd_wait;
   logic               txrr_wait;
   logic [63:0]        tx_data_slow;
   logic [3:0]         tx_frame_slow;
   logic               tx_rd_wait;
   logic               tx_wr_wait;
   logic               etx_cfg_access;
   emesh_packet_t      etx_cfg_packet;
   logic               etx_cfg_wait;

   logic [31:0]        trace_mem [0:MAXW-1];
   int                 n_lines;
   int                 line;
   logic [31:0]        grp;
   emesh_packet_t      pkt;
   emesh_packet_t      stim_q [0:2][$]; // One queue per source, indexed by etx_src_e
   logic [`ETX_PW-1:0] beat_q [$];      // Zero-extended frame and data of each beat
   emesh_packet_t      cfg_q [$];
   logic               last_write;      // Write bit of the last beat 0 taken
   logic               beat_stall;

   etx_core i_dut (
      .clk(clk), .rst(rst),
      .txwr_access(txwr_access), .txwr_packet(txwr_packet), .txwr_wait(txwr_wait),
      .txrd_access(txrd_access), .txrd_packet(txrd_packet), .txrd_wait(txrd_wait),
      .txrr_access(txrr_access), .txrr_packet(txrr_packet), .txrr_wait(txrr_wait),
      .tx_data_slow(tx_data_slow), .tx_frame_slow(tx_frame_slow),
      .tx_rd_wait(tx_rd_wait), .tx_wr_wait(tx_wr_wait),
      .etx_cfg_access(etx_cfg_access), .etx_cfg_packet(etx_cfg_packet),
      .etx_cfg_wait(etx_cfg_wait)
   );

   // Fill for words the trace file leaves unloaded
   function automatic logic [31:0] fill_word(input int idx);
      return {22'h3f_ffff, idx[9:0]};
   endfunction

   function automatic logic [31:0] trace_word(input int ln, input int col);
      int idx;
      idx = ln * NCOL + col;
      return trace_mem[idx[9:0]];
   endfunction

   function automatic etx_src_e line_src(input int ln);
      logic [31:0] w;
      w = trace_word(ln, 2);
      return etx_src_e'(w[1:0]);
   endfunction

   function automatic emesh_packet_t line_packet(input int ln);
      emesh_packet_t p;
      logic [31:0]   w;
      w = trace_word(ln, 3);
      p.write = w[0];
      w = trace_word(ln, 4);
      p.datamode = w[1:0];
      w = trace_word(ln, 5);
      p.ctrlmode = w[4:0];
      p.dstaddr  = trace_word(ln, 6);
      p.data     = trace_word(ln, 7);
      p.srcaddr  = trace_word(ln, 8);
      return p;
   endfunction

   task automatic stop_run(input string why);
      $display("%s at time %0t", why, $time);
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic check_value(input logic [`ETX_PW-1:0] got, input logic [`ETX_PW-1:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
         $display("*** FAILED ***");
         $fatal(1, "Mismatch");
      end
   endtask

   task automatic set_source(input etx_src_e src, input logic acc, input emesh_packet_t p);
      case (src)
         SRC_RR: begin
            txrr_access <= acc;
            txrr_packet <= p;
         end
         SRC_RD: begin
            txrd_access <= acc;
            txrd_packet <= p;
         end
         default: begin
            txwr_access <= acc;
            txwr_packet <= p;
         end
      endcase
   endtask

   function automatic logic source_wait(input etx_src_e src);
      case (src)
         SRC_RR:  return txrr_wait;
         SRC_RD:  return txrd_wait;
         default: return txwr_wait;
      endcase
   endfunction

   // Holds each packet until an edge with wait low
   task automatic drive_source(input etx_src_e src);
      emesh_packet_t p;
      logic          stalled;
      while (stim_q[src].size() > 0) begin
         p = stim_q[src].pop_front();
         set_source(src, 1'b1, p);
         do begin
            @(negedge clk);
            stalled = source_wait(src); // Settled by mid cycle
            @(posedge clk);
         end while (stalled);
      end
      set_source(src, 1'b0, '0);
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Random back-pressure on all three external waits
   initial begin
      void'($urandom(32'hfe2b_1678));
      forever begin
         @(posedge clk);
         if (!rst) begin
            tx_rd_wait   <= ($urandom % 3) == 0; // Busy about a third of the time
            tx_wr_wait   <= ($urandom % 3) == 0;
            etx_cfg_wait <= ($urandom % 3) == 0;
         end
      end
   end

   // Stall of the beat on the pins
   // Beat 1 takes the write bit of its beat 0
   assign beat_stall = ((tx_frame_slow == 4'hF) ? tx_data_slow[0] : last_write) ?
                       tx_wr_wait : tx_rd_wait;

   always @(negedge clk) begin
      if (!rst && tx_frame_slow != 4'h0 && !beat_stall) begin
         if (beat_q.size() == 0)
            stop_run("Tx beat appeared with no packet expected");
         else
            check_value({36'h0, tx_frame_slow, tx_data_slow}, beat_q.pop_front(), "tx beat");
         if (tx_frame_slow == 4'hF)
            last_write <= tx_data_slow[0];
      end
   end

   always @(negedge clk) begin
      if (!rst && etx_cfg_access && !etx_cfg_wait) begin
         if (cfg_q.size() == 0)
            stop_run("Cfg response appeared with none expected");
         else
            check_value(etx_cfg_packet, cfg_q.pop_front(), "cfg response");
      end
   end

   initial begin
      rst          <= 1'b1;
      txwr_access  <= 1'b0;
      txrd_access  <= 1'b0;
      txrr_access  <= 1'b0;
      txwr_packet  <= '0;
      txrd_packet  <= '0;
      txrr_packet  <= '0;
      tx_rd_wait   <= 1'b0;
      tx_wr_wait   <= 1'b0;
      etx_cfg_wait <= 1'b0;
      last_write   <= 1'b0;
      for (int i = 0; i < MAXW; i++)
         trace_mem[i[9:0]] = fill_word(i); // Marks the end of the trace
      $readmemh("tests/etx_core_trace.txt", trace_mem);
      n_lines = 0;
      while (n_lines < MAXW / NCOL &&
             trace_word(n_lines, 0) != fill_word(n_lines * NCOL))
         n_lines++;
      if (n_lines == 0)
         stop_run("Trace file is empty or missing");
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      line = 0;
      while (line < n_lines) begin
         grp = trace_word(line, 0);
         while (line < n_lines && trace_word(line, 0) == grp) begin
            pkt = line_packet(line);
            case (trace_word(line, 1))
               32'd0: stim_q[line_src(line)].push_back(pkt);
               32'd1: begin
                  // Address beat followed by data beat
                  beat_q.push_back({36'h0, 4'hF, pkt.dstaddr, 24'h0,
                                    pkt.ctrlmode, pkt.datamode, pkt.write});
                  beat_q.push_back({36'h0, 4'h7, pkt.data, pkt.srcaddr});
               end
               32'd2: cfg_q.push_back(pkt);
               default: stop_run("Unknown line kind in trace file");
            endcase
            line++;
         end
         @(posedge clk);
         fork
            drive_source(SRC_RR);
            drive_source(SRC_RD);
            drive_source(SRC_WR);
         join
         while (beat_q.size() != 0 || cfg_q.size() != 0)
            @(posedge clk);
         repeat (GAP) @(posedge clk); // Any stray output shows up here
      end
      $display("*** PASSED ***");
      $finish;
   end

   initial begin
      #1;
      repeat (LINE_CYC * n_lines + 16) @(posedge clk);
      stop_run("Timeout, the trace did not complete within its cycle budget");
   end

endmodule

//--- tests/etx_core_trace.txt
// grp kind src write datamode ctrlmode dstaddr data srcaddr (hex)
// kind 0 stimulus on src (0 rr, 1 rd, 2 wr), 1 expected tx packet, 2 expected cfg response
1 0 2 1 2 00 20001000 11112222 00000aa0
2 0 2 1 2 00 99900000 00000001 00000000
2 1 0 1 2 00 20001000 11112222 00000aa0
3 0 2 1 2 00 99900004 00000f0f 00000000
3 0 2 1 2 00 99900008 00000ab5 00000000
4 0 1 0 2 00 99900004 00000000 00000bb0
4 0 1 0 2 00 9990000c 00000000 00000bb4
4 0 1 0 2 00 99900010 00000000 00000bb8
4 2 0 1 2 00 00000bb0 00000f0f 99900004
4 2 0 1 2 00 00000bb4 45540102 9990000c
4 2 0 1 2 00 00000bb8 00000000 99900010
5 0 0 1 2 00 30002000 aaaa0001 00000cc0
5 0 1 0 2 00 40003000 00000000 00000cc4
5 0 2 1 1 00 50004000 bbbb0002 00000cc8
5 1 0 1 2 00 30002000 aaaa0001 00000cc0
5 1 0 0 2 00 40003000 00000000 00000cc4
5 1 0 1 1 00 50004000 bbbb0002 00000cc8
6 0 2 1 2 00 99900000 00000003 00000000
7 0 0 1 2 00 30002000 aaaa0003 00000cd0
7 0 1 0 2 00 40003000 00000000 00000cd4
7 0 2 1 2 00 56789abc bbbb0004 00000cd8
7 1 0 1 2 00 30002000 aaaa0003 00000cd0
7 1 0 0 2 00 a0503000 00000000 00000cd4
7 1 0 1 2 00 a6589abc bbbb0004 00000cd8
8 0 2 1 2 00 99900000 000000a5 00000000
9 0 0 1 2 13 31000000 aaaa0005 00000ce0
9 0 1 0 2 10 41000000 00000000 00000ce4
9 0 2 1 3 03 51000000 bbbb0006 00000ce8
9 1 0 1 2 13 31000000 aaaa0005 00000ce0
9 1 0 0 2 1a 41000000 00000000 00000ce4
9 1 0 1 3 0a 51000000 bbbb0006 00000ce8

//--- verilog/etx_arbiter.sv
`timescale 1ns/100ps
`include "etx_config.svh"

module etx_arbiter (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   txwr_access,
   input  logic                   txrd_access,
   input  logic                   txrr_access,
   input  etx_pkg::emesh_packet_t txwr_packet,
   input  etx_pkg::emesh_packet_t txrd_packet,
   input  etx_pkg::emesh_packet_t txrr_packet,
   output logic                   txwr_wait,
   output logic                   txrd_wait,
   output logic                   txrr_wait,
   input  logic                   etx_rd_wait,
   input  logic                   etx_wr_wait,
   input  logic                   cfg_busy,
   input  logic                   ctrlmode_override,
   input  logic [3:0]             ctrlmode,
   output logic                   link_access,
   output logic                   cfg_access,
   output etx_pkg::emesh_packet_t link_packet,
   output etx_pkg::emesh_packet_t cfg_packet,
   output logic                   link_rr
);
   import etx_pkg::*;

   etx_src_e      sel_src;    // Winning source
   emesh_packet_t sel_pkt;
   emesh_packet_t fwd_pkt;    // Winner after ctrlmode override
   emesh_packet_t pkt_q;      // Output register, shared by both paths
   logic          any_req;
   logic          sel_is_cfg; // Winner targets our own registers
   logic          out_stall;
   logic          out_move;
   logic          out_free;
   logic          grant;

   // Fixed priority, rr over rd over wr
   always_comb begin
      sel_src = SRC_WR;
      sel_pkt = txwr_packet;
      if (txrr_access) begin
         sel_src = SRC_RR;
         sel_pkt = txrr_packet;
      end else if (txrd_access) begin
         sel_src = SRC_RD;
         sel_pkt = txrd_packet;
      end
   end

   always_comb begin
      fwd_pkt = sel_pkt;
      if (ctrlmode_override && sel_src != SRC_RR)
         fwd_pkt.ctrlmode[3:0] = ctrlmode; // Responses keep their own mode
   end

   assign any_req    = txrr_access | txrd_access | txwr_access;
   assign sel_is_cfg = sel_pkt.dstaddr[31:20] == `ETX_ID; // Single ID compare

   // Reads stall on rd wait, everything else on wr wait
   assign out_stall = link_packet.write ? etx_wr_wait : etx_rd_wait;
   assign out_move  = (link_access & ~out_stall) | (cfg_access & ~cfg_busy);
   assign out_free  = ~(link_access | cfg_access) | out_move;
   assign grant     = any_req & out_free & ~(sel_is_cfg & cfg_busy);

   assign txrr_wait = txrr_access & ~(grant & (sel_src == SRC_RR));
   assign txrd_wait = txrd_access & ~(grant & (sel_src == SRC_RD));
   assign txwr_wait = txwr_access & ~(grant & (sel_src == SRC_WR));

   always_ff @(posedge clk) begin
      if (rst) begin
         link_access <= 1'b0;
         cfg_access  <= 1'b0;
         link_rr     <= 1'b0;
      end else if (out_free) begin
         link_access <= grant & ~sel_is_cfg;
         cfg_access  <= grant & sel_is_cfg; // Never both at once
         link_rr     <= grant & (sel_src == SRC_RR);
      end
   end

   always_ff @(posedge clk) begin
      if (grant)
         pkt_q <= fwd_pkt;
   end

   assign link_packet = pkt_q;
   assign cfg_packet  = pkt_q;

endmodule

//--- verilog/etx_cfg.sv
`timescale 1ns/100ps
`include "etx_config.svh"

module etx_cfg (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   cfg_access,
   input  etx_pkg::emesh_packet_t cfg_packet,
   output logic                   cfg_busy,
   output logic                   etx_cfg_access,
   output etx_pkg::emesh_packet_t etx_cfg_packet,
   input  logic                   etx_cfg_wait,
   output logic                   tx_enable,
   output logic                   remap_enable,
   output logic                   ctrlmode_override,
   output logic [3:0]             ctrlmode,
   output logic [11:0]            remap_mask,
   output logic [11:0]            remap_pattern
);
   import etx_pkg::*;

   logic [7:0]    ctrl_q;   // Upper control bits read back as zero
   logic [7:0]    reg_addr;
   logic          accept;
   logic          wr_en;
   logic          rd_en;
   logic [31:0]   rd_data;
   emesh_packet_t resp;

   // One response slot, no new access until it is taken
   assign cfg_busy = etx_cfg_access;

   assign accept   = cfg_access & ~cfg_busy;
   assign wr_en    = accept & cfg_packet.write;
   assign rd_en    = accept & ~cfg_packet.write;
   assign reg_addr = cfg_packet.dstaddr[7:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_q        <= 8'h00;
         remap_mask    <= 12'h000;
         remap_pattern <= 12'h000;
      end else if (wr_en) begin
         case (reg_addr)
            `ETX_REG_CTRL:       ctrl_q        <= cfg_packet.data[7:0];
            `ETX_REG_REMAP_MASK: remap_mask    <= cfg_packet.data[11:0];
            `ETX_REG_REMAP_PAT:  remap_pattern <= cfg_packet.data[11:0];
            default: ; // Version is read only, unknown offsets dropped
         endcase
      end
   end

   always_comb begin
      case (reg_addr)
         `ETX_REG_CTRL:       rd_data = {24'h0, ctrl_q};
         `ETX_REG_REMAP_MASK: rd_data = {20'h0, remap_mask};
         `ETX_REG_REMAP_PAT:  rd_data = {20'h0, remap_pattern};
         `ETX_REG_VERSION:    rd_data = `ETX_VERSION;
         default:             rd_data = 32'h0;
      endcase
   end

   // Response goes back to the requester, addresses swapped
   always_comb begin
      resp          = cfg_packet;
      resp.write    = 1'b1;
      resp.dstaddr  = cfg_packet.srcaddr;
      resp.data     = rd_data;
      resp.srcaddr  = cfg_packet.dstaddr;
   end

   always_ff @(posedge clk) begin
      if (rst)
         etx_cfg_access <= 1'b0;
      else if (rd_en)
         etx_cfg_access <= 1'b1;
      else if (!etx_cfg_wait)
         etx_cfg_access <= 1'b0; // Taken by the receiver
   end

   always_ff @(posedge clk) begin
      if (rd_en)
         etx_cfg_packet <= resp;
   end

   // Control fields out to the datapath
   assign tx_enable         = ctrl_q[`ETX_CTRL_TX_EN];
   assign remap_enable      = ctrl_q[`ETX_CTRL_REMAP_EN];
   assign ctrlmode_override = ctrl_q[`ETX_CTRL_CM_OVR];
   assign ctrlmode          = ctrl_q[`ETX_CTRL_CM_MSB:`ETX_CTRL_CM_LSB];

endmodule

//--- verilog/etx_config.svh
`ifndef ETX_CONFIG_SVH
`define ETX_CONFIG_SVH

// Mesh packet width in bits
`define ETX_PW 104

// Link ID, matched against dstaddr[31:20]
`define ETX_ID 12'h999

// Register offsets within the link's own space (dstaddr[7:0])
`define ETX_REG_CTRL       8'h00
`define ETX_REG_REMAP_MASK 8'h04
`define ETX_REG_REMAP_PAT  8'h08
`define ETX_REG_VERSION    8'h0C

// Read-only version word
`define ETX_VERSION 32'h4554_0102

// Control register bit positions
`define ETX_CTRL_TX_EN    0 // Serializer enable
`define ETX_CTRL_REMAP_EN 1 // Address remap enable
`define ETX_CTRL_CM_OVR   2 // Replace ctrlmode on outgoing packets
`define ETX_CTRL_CM_LSB   4
`define ETX_CTRL_CM_MSB   7

`endif

//--- verilog/etx_core.sv
`timescale 1ns/100ps

module etx_core (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   txwr_access,
   input  etx_pkg::emesh_packet_t txwr_packet,
   output logic                   txwr_wait,
   input  logic                   txrd_access,
   input  etx_pkg::emesh_packet_t txrd_packet,
   output logic                   txrd_wait,
   input  logic                   txrr_access,
   input  etx_pkg::emesh_packet_t txrr_packet,
   output logic                   txrr_wait,
   output logic [63:0]            tx_data_slow,
   output logic [3:0]             tx_frame_slow,
   input  logic                   tx_rd_wait,
   input  logic                   tx_wr_wait,
   output logic                   etx_cfg_access,
   output etx_pkg::emesh_packet_t etx_cfg_packet,
   input  logic                   etx_cfg_wait
);
   import etx_pkg::*;

   // Arbiter outputs
   logic          link_access;
   emesh_packet_t link_packet;
   logic          link_rr;
   logic          cfg_access;
   emesh_packet_t cfg_packet;
   logic          cfg_busy;
   // Remap to serializer
   logic          remap_access;
   emesh_packet_t remap_packet;
   logic          etx_rd_wait;   // Serializer back-pressure
   logic          etx_wr_wait;
   // Control fields
   logic          tx_enable;
   logic          remap_enable;
   logic          ctrlmode_override;
   logic [3:0]    ctrlmode;
   logic [11:0]   remap_mask;
   logic [11:0]   remap_pattern;

   etx_arbiter etx_arbiter (
      .clk(clk), .rst(rst),
      .txwr_access(txwr_access), .txrd_access(txrd_access), .txrr_access(txrr_access),
      .txwr_packet(txwr_packet), .txrd_packet(txrd_packet), .txrr_packet(txrr_packet),
      .txwr_wait(txwr_wait), .txrd_wait(txrd_wait), .txrr_wait(txrr_wait),
      .etx_rd_wait(etx_rd_wait), .etx_wr_wait(etx_wr_wait),
      .cfg_busy(cfg_busy),
      .ctrlmode_override(ctrlmode_override), .ctrlmode(ctrlmode),
      .link_access(link_access), .cfg_access(cfg_access),
      .link_packet(link_packet), .cfg_packet(cfg_packet),
      .link_rr(link_rr)
   );

   etx_remap etx_remap (
      .clk(clk), .rst(rst),
      .link_access(link_access), .link_packet(link_packet), .link_rr(link_rr),
      .remap_enable(remap_enable), .remap_mask(remap_mask), .remap_pattern(remap_pattern),
      .etx_rd_wait(etx_rd_wait), .etx_wr_wait(etx_wr_wait),
      .remap_access(remap_access), .remap_packet(remap_packet)
   );

   etx_cfg etx_cfg (
      .clk(clk), .rst(rst),
      .cfg_access(cfg_access), .cfg_packet(cfg_packet), .cfg_busy(cfg_busy),
      .etx_cfg_access(etx_cfg_access), .etx_cfg_packet(etx_cfg_packet),
      .etx_cfg_wait(etx_cfg_wait),
      .tx_enable(tx_enable), .remap_enable(remap_enable),
      .ctrlmode_override(ctrlmode_override), .ctrlmode(ctrlmode),
      .remap_mask(remap_mask), .remap_pattern(remap_pattern)
   );

   etx_protocol etx_protocol (
      .clk(clk), .rst(rst),
      .remap_access(remap_access), .remap_packet(remap_packet),
      .tx_enable(tx_enable),
      .tx_rd_wait(tx_rd_wait), .tx_wr_wait(tx_wr_wait),
      .etx_rd_wait(etx_rd_wait), .etx_wr_wait(etx_wr_wait),
      .tx_data_slow(tx_data_slow), .tx_frame_slow(tx_frame_slow)
   );

endmodule

//--- verilog/etx_pkg.sv
package etx_pkg;

   // Mesh packet, write bit in the lsb
   typedef struct packed {
      logic [31:0] srcaddr;  // Return address for reads
      logic [31:0] data;
      logic [31:0] dstaddr;  // Bits 31:20 carry the target ID
      logic [4:0]  ctrlmode;
      logic [1:0]  datamode; // Transfer size
      logic        write;    // 0 for read requests
   } emesh_packet_t;

   // Arbiter sources, listed in priority order
   typedef enum logic [1:0] {
      SRC_RR = 2'd0, // Read responses
      SRC_RD = 2'd1, // Read requests
      SRC_WR = 2'd2  // Write requests
   } etx_src_e;

   // Serializer states
   typedef enum logic [1:0] {
      TX_IDLE  = 2'd0,
      TX_BEAT0 = 2'd1, // Address and control beat on the pins
      TX_BEAT1 = 2'd2  // Data and srcaddr beat on the pins
   } etx_tx_state_e;

endpackage

//--- verilog/etx_protocol.sv
`timescale 1ns/100ps
`include "etx_config.svh"

module etx_protocol (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   remap_access,
   input  etx_pkg::emesh_packet_t remap_packet,
   input  logic                   tx_enable,
   input  logic                   tx_rd_wait,
   input  logic                   tx_wr_wait,
   output logic                   etx_rd_wait,
   output logic                   etx_wr_wait,
   output logic [63:0]            tx_data_slow,
   output logic [3:0]             tx_frame_slow
);
   import etx_pkg::*;

   etx_tx_state_e       state_q;
   etx_tx_state_e       state_nxt;
   logic [`ETX_PW-1:0]  pkt_q;      // Packet being serialized
   emesh_packet_t       pkt;
   logic                tx_stall;   // Current beat cannot complete
   logic                beat1_done;
   logic                can_accept;
   logic                in_move;

   assign pkt = emesh_packet_t'(pkt_q);

   // Wait that matches the packet in flight, plus the global enable
   assign tx_stall   = ~tx_enable | (pkt.write ? tx_wr_wait : tx_rd_wait);
   assign beat1_done = (state_q == TX_BEAT1) & ~tx_stall;
   assign can_accept = (state_q == TX_IDLE) | beat1_done;
   assign in_move    = remap_access & can_accept;

   // Either packet type fits once the serializer frees up
   assign etx_rd_wait = ~can_accept;
   assign etx_wr_wait = ~can_accept;

   always_comb begin
      state_nxt = state_q;
      case (state_q)
         TX_IDLE:  if (in_move) state_nxt = TX_BEAT0;
         TX_BEAT0: if (!tx_stall) state_nxt = TX_BEAT1;
         TX_BEAT1: begin
            if (!tx_stall)
               state_nxt = in_move ? TX_BEAT0 : TX_IDLE; // Back to back
         end
         default:  state_nxt = TX_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst)
         state_q <= TX_IDLE;
      else
         state_q <= state_nxt;
   end

   always_ff @(posedge clk) begin
      if (in_move)
         pkt_q <= remap_packet;
   end

   // Pins stay idle while the link is disabled
   always_comb begin
      tx_data_slow  = 64'h0;
      tx_frame_slow = 4'h0;
      if (tx_enable) begin
         case (state_q)
            TX_BEAT0: begin
               tx_data_slow  = {pkt.dstaddr, 24'h0, pkt.ctrlmode, pkt.datamode, pkt.write};
               tx_frame_slow = 4'hF;
            end
            TX_BEAT1: begin
               tx_data_slow  = {pkt.data, pkt.srcaddr};
               tx_frame_slow = 4'h7; // End of packet
            end
            default: ;
         endcase
      end
   end

endmodule

//--- verilog/etx_remap.sv
`timescale 1ns/100ps

module etx_remap (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   link_access,
   input  etx_pkg::emesh_packet_t link_packet,
   input  logic                   link_rr,
   input  logic                   remap_enable,
   input  logic [11:0]            remap_mask,
   input  logic [11:0]            remap_pattern,
   input  logic                   etx_rd_wait,
   input  logic                   etx_wr_wait,
   output logic                   remap_access,
   output etx_pkg::emesh_packet_t remap_packet
);
   import etx_pkg::*;

   emesh_packet_t remapped;
   logic          out_stall; // Held packet cannot leave
   logic          in_move;   // Arbiter packet is taken this cycle

   // Pattern bits replace the ID field where the mask is set
   always_comb begin
      remapped = link_packet;
      if (remap_enable && !link_rr) begin
         remapped.dstaddr[31:20] = (link_packet.dstaddr[31:20] & ~remap_mask) |
                                   (remap_pattern & remap_mask);
      end
   end

   // Same wait selection as the arbiter uses for its link output
   assign out_stall = remap_access & (remap_packet.write ? etx_wr_wait : etx_rd_wait);
   assign in_move   = link_access & ~(link_packet.write ? etx_wr_wait : etx_rd_wait);

   always_ff @(posedge clk) begin
      if (rst)
         remap_access <= 1'b0;
      else if (!out_stall)
         remap_access <= in_move; // Empties when nothing arrives
   end

   always_ff @(posedge clk) begin
      if (!out_stall && in_move)
         remap_packet <= remapped;
   end

endmodule
